//--- verilog/file_loader_pkg.sv
/*
 * shared types for the spi file download path
 * the address is counted on 25 bits, so files up to 32 MB can be addressed
 * RAM depth is set separately by ADDR_W at the top level
 */

package file_loader_pkg;

	// ******************************
	// widths with a meaning
	// ******************************

	// one byte shifted over spi, also one RAM word
	typedef logic [7:0] spi_byte_t;

	// command byte at the start of every transfer
	typedef logic [7:0] spi_cmd_t;

	// download address, counted in the sck domain
	typedef logic [24:0] load_addr_t;

	// osd menu index of the file being sent
	typedef logic [4:0] file_index_t;

	// ******************************
	// io controller commands
	// ******************************

	// payload bit 0 starts (1) or ends (0) a download
	localparam spi_cmd_t CMD_FILE_TX = 8'h53;
	// every payload byte is file data
	localparam spi_cmd_t CMD_FILE_TX_DAT = 8'h54;
	// payload low five bits give the menu index
	localparam spi_cmd_t CMD_FILE_INDEX = 8'h55;

	// write record handed from the sck side to the RAM, 33 bits
	typedef struct packed {
		load_addr_t addr;
		spi_byte_t  data;
	} load_wr_t;

endpackage

//--- verilog/spi_cmd_receiver.sv
/*
 * spi slave for the io controller, sck domain only, mode 0, msb first
 * the first byte of a transfer is the command, every later byte is payload
 * load_wr stays stable for eight sck cycles after wr_pulse rises
 */

`timescale 1ns/1ns

module spi_cmd_receiver import file_loader_pkg::*; (
	input  logic        sck,
	input  logic        ss,
	input  logic        spi_ss,
	input  logic        sdi,
	output logic        wr_pulse,
	output load_wr_t    load_wr,
	output logic        downloading,
	output file_index_t index
);

	// ******************************
	// receive state
	// ******************************

	// 0..7 for the command byte, then 8..15 for each payload byte
	logic [3:0] bit_cnt;
	// first seven bits of the byte in flight
	logic [6:0] sbuf;
	// command latched at the end of the first byte
	spi_cmd_t   cmd;
	// next download address
	load_addr_t addr;

	// byte completed with the live bit
	spi_byte_t  rx_byte;
	logic       cmd_done;
	logic       byte_done;

	// the last bit is not shifted in, it is used directly off the pin
	assign rx_byte   = {sbuf, sdi};
	assign cmd_done  = (bit_cnt == 4'd7);
	assign byte_done = (bit_cnt == 4'd15);

	// ******************************
	// bit counter
	// ******************************

	// deselect clears the counter at once, so a partial byte is lost
	// and the next transfer starts again with a command byte
	always_ff @(posedge sck or posedge ss or posedge spi_ss) begin
		if (ss || spi_ss) begin
			bit_cnt <= '0;
		end else if (byte_done) begin
			// wrap back to the start of the next payload byte
			bit_cnt <= 4'd8;
		end else begin
			bit_cnt <= bit_cnt + 4'd1;
		end
	end

	// ******************************
	// shift, decode and write record
	// ******************************

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			sbuf        <= '0;
			cmd         <= '0;
			addr        <= '0;
			wr_pulse    <= 1'b0;
			load_wr     <= '0;
			downloading <= 1'b0;
			index       <= '0;
		end else begin
			// strobe lasts exactly one sck cycle
			wr_pulse <= 1'b0;

			// post-write increment, one edge after the strobe
			if (wr_pulse) begin
				addr <= addr + load_addr_t'(1);
			end

			if (!spi_ss) begin
				sbuf <= {sbuf[5:0], sdi};

				// command byte complete
				if (cmd_done) begin
					cmd <= rx_byte;
				end

				// payload byte complete, act on the latched command
				if (byte_done) begin
					case (cmd)
						CMD_FILE_TX: begin
							if (sdi) begin
								// new download restarts at address zero
								addr        <= '0;
								downloading <= 1'b1;
							end else begin
								downloading <= 1'b0;
							end
						end
						CMD_FILE_TX_DAT: begin
							// hand the byte and its address to the clk side
							load_wr.addr <= addr;
							load_wr.data <= rx_byte;
							wr_pulse     <= 1'b1;
						end
						CMD_FILE_INDEX: begin
							index <= rx_byte[4:0];
						end
						default: begin
							// unknown commands are ignored
						end
					endcase
				end
			end
		end
	end

endmodule

//--- verilog/loader_cdc.sv
/*
 * brings the loader outputs from sck into clk
 * clk must run at least three times faster than sck, or strobes are lost
 * downloading and index are quasi-static and only double registered
 */

`timescale 1ns/1ns

module loader_cdc import file_loader_pkg::*; (
	input  logic        clk,
	input  logic        ss,
	input  logic        wr_pulse,
	input  load_wr_t    load_wr,
	input  logic        downloading_sck,
	input  file_index_t index_sck,
	output logic        wr,
	output load_wr_t    ram_wr,
	output logic        downloading,
	output file_index_t index
);

	// ******************************
	// write strobe
	// ******************************

	// two synchronizer flops plus one more for edge detection
	logic wr_meta;
	logic wr_sync;
	logic wr_sync_d;
	logic wr_rise;

	assign wr_rise = wr_sync && !wr_sync_d;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			wr_meta   <= 1'b0;
			wr_sync   <= 1'b0;
			wr_sync_d <= 1'b0;
			wr        <= 1'b0;
			ram_wr    <= '0;
		end else begin
			wr_meta   <= wr_pulse;
			wr_sync   <= wr_meta;
			wr_sync_d <= wr_sync;

			// one clk cycle per sck strobe
			wr <= wr_rise;

			// load_wr has been stable for several sck cycles by now
			// so it is safe to sample on the synchronized edge
			if (wr_rise) begin
				ram_wr <= load_wr;
			end
		end
	end

	// ******************************
	// quasi-static status
	// ******************************

	logic        dl_meta;
	file_index_t index_meta;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			dl_meta     <= 1'b0;
			downloading <= 1'b0;
			index_meta  <= '0;
			index       <= '0;
		end else begin
			dl_meta     <= downloading_sck;
			downloading <= dl_meta;
			// index bits may settle in different cycles, they only
			// change between files so a one cycle mix is harmless
			index_meta  <= index_sck;
			index       <= index_meta;
		end
	end

endmodule

//--- verilog/download_ram.sv
/*
 * byte RAM of 2**ADDR_W words filled by the loader
 * writes above the RAM depth are dropped, read data comes one clk later
 */

`timescale 1ns/1ns

module download_ram import file_loader_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              wr,
	input  load_wr_t          ram_wr,
	input  logic [ADDR_W-1:0] rd_addr,
	output spi_byte_t         rd_data
);

	localparam int DEPTH = 1 << ADDR_W;

	// storage
	spi_byte_t mem [DEPTH];

	// address inside the array, upper bits all zero
	logic in_range;
	logic [ADDR_W-1:0] wr_addr;

	assign in_range = ((ram_wr.addr >> ADDR_W) == '0);
	assign wr_addr  = ram_wr.addr[ADDR_W-1:0];

	// ******************************
	// write port
	// ******************************

	always_ff @(posedge clk) begin
		if (wr && in_range) begin
			mem[wr_addr] <= ram_wr.data;
		end
	end

	// ******************************
	// read port
	// ******************************

	// registered read, no reset on the data path
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- verilog/file_loader_top.sv
/*
 * file download path, io controller spi into on-chip RAM
 * spi_ss is active low, ss is the system reset
 * clk must be at least three times the sck rate
 */

`timescale 1ns/1ns

module file_loader_top import file_loader_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              ss,
	input  logic              sck,
	input  logic              spi_ss,
	input  logic              sdi,
	input  logic [ADDR_W-1:0] rd_addr,
	output spi_byte_t         rd_data,
	output logic              downloading,
	output file_index_t       index
);

	// ******************************
	// sck domain signals
	// ******************************

	logic        wr_pulse;
	load_wr_t    load_wr;
	logic        downloading_sck;
	file_index_t index_sck;

	// ******************************
	// clk domain signals
	// ******************************

	logic     wr;
	load_wr_t ram_wr;

	// spi slave and command decode
	spi_cmd_receiver u_receiver (
		.sck         (sck),
		.ss          (ss),
		.spi_ss      (spi_ss),
		.sdi         (sdi),
		.wr_pulse    (wr_pulse),
		.load_wr     (load_wr),
		.downloading (downloading_sck),
		.index       (index_sck)
	);

	// crossing from sck into clk
	loader_cdc u_cdc (
		.clk             (clk),
		.ss              (ss),
		.wr_pulse        (wr_pulse),
		.load_wr         (load_wr),
		.downloading_sck (downloading_sck),
		.index_sck       (index_sck),
		.wr              (wr),
		.ram_wr          (ram_wr),
		.downloading     (downloading),
		.index           (index)
	);

	// target memory, read by the core
	download_ram #(
		.ADDR_W (ADDR_W)
	) u_ram (
		.clk     (clk),
		.wr      (wr),
		.ram_wr  (ram_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

//--- include/tb_spi_tasks.svh
/*
 * spi master tasks, mode 0, msb first, one sck period is four clk periods
 * expects clk, sck, spi_ss, sdi and tx_buf in the including module
 */

`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// ******************************
// bit level
// ******************************

// shift the top nbits of one byte, sdi set while sck is low
task automatic shift_bits(input spi_byte_t value, input int nbits);
	for (int i = 0; i < nbits; i++) begin
		@(negedge clk);
		sck = 1'b0;
		sdi = value[7-i];
		// two clk low, then the slave samples on the rising edge
		@(negedge clk);
		@(negedge clk);
		sck = 1'b1;
		@(negedge clk);
	end
endtask

// ******************************
// transfer level
// ******************************

// nbytes full bytes from tx_buf, command first
// cut_bits > 0 adds a truncated byte taken from tx_buf[nbytes]
task automatic send_transfer(input int nbytes, input int cut_bits);
	@(negedge clk);
	spi_ss = 1'b0;
	for (int i = 0; i < nbytes; i++) begin
		shift_bits(tx_buf[i], 8);
	end
	if (cut_bits > 0) begin
		shift_bits(tx_buf[nbytes], cut_bits);
	end
	// back to idle, sck low before deselect
	@(negedge clk);
	sck = 1'b0;
	@(negedge clk);
	spi_ss = 1'b1;
	@(negedge clk);
endtask

`endif

//--- testbench/tb_file_loader.sv
/*
 * testbench for the spi file loader, table driven with a shadow RAM model
 * sck runs at a quarter of clk, inputs change on the falling clk edge
 * only RAM addresses written during the run are read back
 */

`timescale 1ns/1ns

module tb_file_loader import file_loader_pkg::*;;

	localparam int ADDR_W = 10;
	localparam int RAM_DEPTH = 1 << ADDR_W;
	localparam int NUM_ROWS = 13;
	// framing, settle wait and read-back per row, in clk cycles
	localparam int ROW_OVERHEAD = 48;

	// one stimulus row with its expected results
	typedef struct packed {
		spi_cmd_t    cmd;
		logic [7:0]  len;
		logic        rnd;
		spi_byte_t   value;
		logic [3:0]  cut_bits;
		logic        exp_dl;
		file_index_t exp_index;
		logic [7:0]  exp_writes;
	} row_t;

	logic              clk;
	logic              ss;
	logic              sck;
	logic              spi_ss;
	logic              sdi;
	logic [ADDR_W-1:0] rd_addr;
	spi_byte_t         rd_data;
	logic              downloading;
	file_index_t       index;

	row_t      rows [NUM_ROWS];
	spi_byte_t tx_buf [16];

	// shadow RAM and model address
	spi_byte_t shadow [RAM_DEPTH];
	int        model_addr;
	int        hi_water;

	int errors;
	int checks;
	int wr_seen;
	int cycle_cnt;
	int cycle_limit;
	int total_bytes;

	`include "tb_spi_tasks.svh"

	file_loader_top #(
		.ADDR_W (ADDR_W)
	) DUT (
		.clk         (clk),
		.ss          (ss),
		.sck         (sck),
		.spi_ss      (spi_ss),
		.sdi         (sdi),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.downloading (downloading),
		.index       (index)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ******************************
	// monitors
	// ******************************

	// count clk-domain write strobes
	always @(posedge clk) begin
		if (!ss && DUT.wr) begin
			wr_seen = wr_seen + 1;
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: run did not finish within %0d clk cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	// ******************************
	// table and model
	// ******************************

	// cmd, len, rnd, value, cut, downloading, index, writes
	task automatic load_table();
		rows[0]  = '{CMD_FILE_TX, 8'd1, 1'b0, 8'h01, 4'd0, 1'b1, 5'h00, 8'd0};
		rows[1]  = '{CMD_FILE_TX_DAT, 8'd6, 1'b1, 8'h00, 4'd0, 1'b1, 5'h00, 8'd6};
		rows[2]  = '{CMD_FILE_TX_DAT, 8'd5, 1'b1, 8'h00, 4'd0, 1'b1, 5'h00, 8'd5};
		rows[3]  = '{CMD_FILE_INDEX, 8'd1, 1'b0, 8'hE7, 4'd0, 1'b1, 5'h07, 8'd0};
		rows[4]  = '{8'h56, 8'd3, 1'b0, 8'h00, 4'd0, 1'b1, 5'h07, 8'd0};
		rows[5]  = '{CMD_FILE_TX, 8'd1, 1'b0, 8'h00, 4'd0, 1'b0, 5'h07, 8'd0};
		rows[6]  = '{CMD_FILE_TX, 8'd1, 1'b0, 8'h01, 4'd0, 1'b1, 5'h07, 8'd0};
		rows[7]  = '{CMD_FILE_TX_DAT, 8'd4, 1'b1, 8'h00, 4'd0, 1'b1, 5'h07, 8'd4};
		rows[8]  = '{CMD_FILE_TX_DAT, 8'd2, 1'b1, 8'h3C, 4'd4, 1'b1, 5'h07, 8'd2};
		rows[9]  = '{CMD_FILE_TX_DAT, 8'd3, 1'b1, 8'h00, 4'd0, 1'b1, 5'h07, 8'd3};
		rows[10] = '{CMD_FILE_INDEX, 8'd1, 1'b0, 8'h3A, 4'd0, 1'b1, 5'h1A, 8'd0};
		rows[11] = '{8'h00, 8'd2, 1'b0, 8'h55, 4'd0, 1'b1, 5'h1A, 8'd0};
		rows[12] = '{CMD_FILE_TX, 8'd1, 1'b0, 8'hFE, 4'd0, 1'b0, 5'h1A, 8'd0};
	endtask

	// one complete payload byte under the given command
	task automatic update_model(input spi_cmd_t cmd, input spi_byte_t b);
		if (cmd == CMD_FILE_TX && b[0]) begin
			model_addr = 0;
		end else if (cmd == CMD_FILE_TX_DAT) begin
			if (model_addr < RAM_DEPTH) begin
				shadow[model_addr] = b;
			end
			model_addr++;
			if (model_addr > hi_water) begin
				hi_water = model_addr;
			end
		end
	endtask

	// ******************************
	// checks
	// ******************************

	task automatic read_back();
		for (int a = 0; a < hi_water; a++) begin
			@(negedge clk);
			rd_addr = a[ADDR_W-1:0];
			// registered read, data stable at the next falling edge
			@(negedge clk);
			checks++;
			if (rd_data !== shadow[a]) begin
				errors++;
				$display("error at %0t ns: RAM[%0d] is %h, expected %h",
					$time, a, rd_data, shadow[a]);
			end
		end
	endtask

	task automatic run_row(input int r, input row_t row);
		int nbytes;
		int writes_before;
		spi_byte_t b;
		nbytes = 1 + int'(row.len);
		tx_buf[0] = row.cmd;
		for (int i = 1; i < nbytes; i++) begin
			b = row.rnd ? spi_byte_t'($urandom) : row.value;
			tx_buf[i] = b;
			update_model(row.cmd, b);
		end
		// truncated byte, never reaches the model
		tx_buf[nbytes] = row.value;
		writes_before = wr_seen;
		send_transfer(nbytes, int'(row.cut_bits));
		repeat (8) @(negedge clk);
		checks += 3;
		if (downloading !== row.exp_dl) begin
			errors++;
			$display("error at %0t ns: row %0d downloading is %0b, expected %0b",
				$time, r, downloading, row.exp_dl);
		end
		if (index !== row.exp_index) begin
			errors++;
			$display("error at %0t ns: row %0d index is %h, expected %h",
				$time, r, index, row.exp_index);
		end
		if (wr_seen - writes_before != int'(row.exp_writes)) begin
			errors++;
			$display("error at %0t ns: row %0d saw %0d writes, expected %0d",
				$time, r, wr_seen - writes_before, row.exp_writes);
		end
		read_back();
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		ss = 1'b1;
		sck = 1'b0;
		spi_ss = 1'b1;
		sdi = 1'b0;
		rd_addr = '0;
		errors = 0;
		checks = 0;
		wr_seen = 0;
		cycle_cnt = 0;
		model_addr = 0;
		hi_water = 0;
		void'($urandom(32'ha1a7));
		load_table();
		total_bytes = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			total_bytes += 1 + int'(rows[r].len) + ((rows[r].cut_bits != 4'd0) ? 1 : 0);
		end
		cycle_limit = total_bytes * 32 + NUM_ROWS * ROW_OVERHEAD + 200;
		repeat (3) @(negedge clk);
		ss = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r, rows[r]);
		end
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+include
verilog/file_loader_pkg.sv
verilog/spi_cmd_receiver.sv
verilog/loader_cdc.sv
verilog/download_ram.sv
verilog/file_loader_top.sv
testbench/tb_file_loader.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the file loader testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing -j 0 \
	--top-module tb_file_loader \
	-f files.f \
	-o tb_sim

./obj_dir/tb_sim | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi

echo "simulation finished, log in $LOG"
